/* rtl/mipsPkg.sv */
package mipsPkg;

	////////////////////////////////////////
	// Instruction word
	////////////////////////////////////////

	// One 32-bit word, three field layouts
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;    // Unused by this subset
			logic [5:0] func;
		} rFmt;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm16;
		} iFmt;
		struct packed {
			logic [5:0]  op;
			logic [25:0] target26;
		} jFmt;
	} instrWord_t;

	// Opcodes
	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_SW    = 6'b101011;
	localparam logic [5:0] OP_BEQ   = 6'b000100;
	localparam logic [5:0] OP_LUI   = 6'b001111;
	localparam logic [5:0] OP_J     = 6'b000010;
	localparam logic [5:0] OP_JAL   = 6'b000011;

	// R-type function field
	localparam logic [5:0] FN_ADD = 6'b100000;
	localparam logic [5:0] FN_SUB = 6'b100010;
	localparam logic [5:0] FN_CLO = 6'b100001;
	localparam logic [5:0] FN_JR  = 6'b001000;

	////////////////////////////////////////
	// Control encodings
	////////////////////////////////////////

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_OR  = 3'd2,
		ALU_LUI = 3'd5,
		ALU_CLO = 3'd7
	} aluOp_t;

	typedef enum logic [1:0] {
		NPC_SEQ  = 2'd0,
		NPC_JUMP = 2'd1,    // j and jal
		NPC_BEQ  = 2'd2,
		NPC_JR   = 2'd3
	} npcOp_t;

	typedef enum logic [1:0] {DST_RT = 2'd0, DST_RD = 2'd1, DST_RA = 2'd2} regDst_t;
	typedef enum logic [1:0] {WB_ALU = 2'd0, WB_MEM = 2'd1, WB_PC8 = 2'd2} wbSel_t;

	// Forwarding mux selects
	localparam logic [1:0] FWD_REG = 2'd0;    // Own value
	localparam logic [1:0] FWD_MEM = 2'd1;    // Memory stage result
	localparam logic [1:0] FWD_WB  = 2'd2;    // Writeback value

	localparam logic [31:0] RESET_PC = 32'h0000_3000;

endpackage

/* rtl/pipeBus.sv */
`timescale 1ns/1ps

// Decoded controls of the instruction sitting in Decode
interface ctrlBus;

	mipsPkg::regDst_t regDst;       // Which field names the destination
	logic             regWrite;     // Writes the register file in Writeback
	logic             extSigned;    // Sign-extend imm16, else zero-extend
	logic             aluSrcImm;    // ALU b from immediate
	mipsPkg::aluOp_t  aluOp;
	logic             memWrite;     // Store
	mipsPkg::wbSel_t  wbSel;        // Result source
	mipsPkg::npcOp_t  npcOp;        // Resolved in Decode
	logic             useRs;        // Really reads rs
	logic             useRt;        // Really reads rt

	// Decoder side
	modport drv (
		output regDst,
		output regWrite,
		output extSigned,
		output aluSrcImm,
		output aluOp,
		output memWrite,
		output wbSel,
		output npcOp,
		output useRs,
		output useRt
	);

	// Hazard unit and stage registers
	modport mon (
		input regDst,
		input regWrite,
		input extSigned,
		input aluSrcImm,
		input aluOp,
		input memWrite,
		input wbSel,
		input npcOp,
		input useRs,
		input useRt
	);

endinterface

/* rtl/ctrl.sv */
`timescale 1ns/1ps

module ctrl (
	input  mipsPkg::instrWord_t instr,
	ctrlBus.drv                 bus
);

	logic isR;
	logic isAdd;
	logic isSub;
	logic isClo;
	logic isJr;
	logic isOri;
	logic isLw;
	logic isSw;
	logic isBeq;
	logic isLui;
	logic isJ;
	logic isJal;

	////////////////////////////////////////
	// Per-instruction strobes
	////////////////////////////////////////

	assign isR   = instr.rFmt.op == mipsPkg::OP_RTYPE;
	assign isAdd = isR && (instr.rFmt.func == mipsPkg::FN_ADD);
	assign isSub = isR && (instr.rFmt.func == mipsPkg::FN_SUB);
	assign isClo = isR && (instr.rFmt.func == mipsPkg::FN_CLO);    // Count leading ones
	assign isJr  = isR && (instr.rFmt.func == mipsPkg::FN_JR);

	assign isOri = instr.iFmt.op == mipsPkg::OP_ORI;
	assign isLw  = instr.iFmt.op == mipsPkg::OP_LW;
	assign isSw  = instr.iFmt.op == mipsPkg::OP_SW;
	assign isBeq = instr.iFmt.op == mipsPkg::OP_BEQ;
	assign isLui = instr.iFmt.op == mipsPkg::OP_LUI;
	assign isJ   = instr.jFmt.op == mipsPkg::OP_J;
	assign isJal = instr.jFmt.op == mipsPkg::OP_JAL;

	////////////////////////////////////////
	// Control fields, bit by bit
	////////////////////////////////////////

	// rd for R-type results, r31 for jal
	assign bus.regDst = mipsPkg::regDst_t'({isJal, isAdd | isSub | isClo});

	assign bus.regWrite = isAdd | isSub | isClo | isOri | isLw | isLui | isJal;

	assign bus.extSigned = isLw | isSw;    // Address offsets only
	assign bus.aluSrcImm = isOri | isLw | isSw | isLui;

	// 0 add, 1 sub, 2 or, 5 lui, 7 clo
	assign bus.aluOp = mipsPkg::aluOp_t'({
		isLui | isClo,
		isOri | isClo,
		isSub | isLui | isClo
	});

	assign bus.memWrite = isSw;

	// Load data or link address
	assign bus.wbSel = mipsPkg::wbSel_t'({isJal, isLw});

	// 1 j/jal, 2 beq, 3 jr
	assign bus.npcOp = mipsPkg::npcOp_t'({isBeq | isJr, isJ | isJal | isJr});

	// Source usage for hazard checks
	assign bus.useRs = isAdd | isSub | isClo | isOri | isLw | isSw | isBeq | isJr;
	assign bus.useRt = isAdd | isSub | isSw | isBeq;    // sw data, beq compare

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps

module regFile (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  raddrA,
	input  logic [4:0]  raddrB,
	output logic [31:0] rdataA,
	output logic [31:0] rdataB,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != 5'd0)) begin    // r0 stays zero
			regs[waddr] <= wdata;
		end
	end

	// Writeback data bypasses straight to Decode
	assign rdataA = (raddrA == 5'd0) ? '0 :
	                (we && (raddrA == waddr)) ? wdata : regs[raddrA];
	assign rdataB = (raddrB == 5'd0) ? '0 :
	                (we && (raddrB == waddr)) ? wdata : regs[raddrB];

endmodule

/* rtl/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
	ctrlBus.mon        dCtrl,
	input  logic [4:0] dRs,
	input  logic [4:0] dRt,
	input  logic [4:0] eDst,
	input  logic [4:0] mDst,
	input  logic       eRegWrite,
	input  logic       mRegWrite,
	input  logic       eIsLoad,
	input  logic       mIsLoad,
	input  logic       wRegWrite,
	input  logic [4:0] wDst,
	input  logic [4:0] eRs,
	input  logic [4:0] eRt,
	output logic       stall,
	output logic [1:0] fwdDA,
	output logic [1:0] fwdDB,
	output logic [1:0] fwdEA,
	output logic [1:0] fwdEB
);

	logic isBranch;
	logic loadUse;
	logic brWait;

	// Producer writes src, r0 never matches
	function automatic logic hit(logic wr, logic [4:0] dst, logic [4:0] src);
		return wr && (dst != 5'd0) && (dst == src);
	endfunction

	// Youngest producer wins
	function automatic logic [1:0] pick(logic mHit, logic wHit, logic mLoad);
		if (mHit) begin
			return mLoad ? mipsPkg::FWD_REG : mipsPkg::FWD_MEM;    // Load data not ready yet
		end
		if (wHit) begin
			return mipsPkg::FWD_WB;
		end
		return mipsPkg::FWD_REG;
	endfunction

	////////////////////////////////////////
	// Stall
	////////////////////////////////////////

	assign isBranch = (dCtrl.npcOp == mipsPkg::NPC_BEQ) || (dCtrl.npcOp == mipsPkg::NPC_JR);

	// Any consumer of a load still in Execute
	assign loadUse = (dCtrl.useRs && hit(eIsLoad, eDst, dRs)) ||
	                 (dCtrl.useRt && hit(eIsLoad, eDst, dRt));

	// Compare in Decode needs the value now
	assign brWait = isBranch &&
		((dCtrl.useRs && (hit(eRegWrite, eDst, dRs) || hit(mIsLoad, mDst, dRs))) ||
		 (dCtrl.useRt && (hit(eRegWrite, eDst, dRt) || hit(mIsLoad, mDst, dRt))));

	assign stall = loadUse || brWait;

	// Decode operands, Memory or Writeback
	assign fwdDA = pick(hit(mRegWrite, mDst, dRs), hit(wRegWrite, wDst, dRs), mIsLoad);
	assign fwdDB = pick(hit(mRegWrite, mDst, dRt), hit(wRegWrite, wDst, dRt), mIsLoad);

	// Execute operands, a load never sits in Memory ahead of a user here
	assign fwdEA = pick(hit(mRegWrite, mDst, eRs), hit(wRegWrite, wDst, eRs), 1'b0);
	assign fwdEB = pick(hit(mRegWrite, mDst, eRt), hit(wRegWrite, wDst, eRt), 1'b0);

endmodule

/* rtl/npcUnit.sv */
`timescale 1ns/1ps

module npcUnit (
	input  logic [31:0]         pcD,
	input  mipsPkg::instrWord_t instr,
	input  mipsPkg::npcOp_t     npcOp,
	input  logic [31:0]         rsVal,
	input  logic [31:0]         rtVal,
	output logic                redirect,
	output logic [31:0]         target
);

	logic [31:0] slotPc;      // Delay-slot address
	logic [31:0] brOffset;
	logic        equal;

	assign slotPc   = pcD + 32'd4;
	assign brOffset = {{14{instr.iFmt.imm16[15]}}, instr.iFmt.imm16, 2'b00};
	assign equal    = rsVal == rtVal;    // beq only

	always_comb begin
		case (npcOp)
			mipsPkg::NPC_JUMP: target = {slotPc[31:28], instr.jFmt.target26, 2'b00};
			mipsPkg::NPC_BEQ:  target = slotPc + brOffset;
			mipsPkg::NPC_JR:   target = rsVal;
			default:           target = slotPc;    // Unused, no redirect
		endcase
	end

	// Jumps always, beq on equal
	assign redirect = (npcOp == mipsPkg::NPC_BEQ) ? equal : (npcOp != mipsPkg::NPC_SEQ);

endmodule

/* rtl/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
	input  mipsPkg::aluOp_t op,
	input  logic [31:0]     a,
	input  logic [31:0]     b,
	output logic [31:0]     y
);

	logic [5:0] cloCnt;      // 0..32
	logic       seenZero;

	// Leading ones of a, scan from the MSB
	always_comb begin
		cloCnt   = 6'd0;
		seenZero = 1'b0;
		for (int i = 31; i >= 0; i--) begin
			if (!a[i]) begin
				seenZero = 1'b1;
			end else if (!seenZero) begin
				cloCnt = cloCnt + 6'd1;
			end
		end
	end

	always_comb begin
		case (op)
			mipsPkg::ALU_ADD: y = a + b;    // Wraps, no trap
			mipsPkg::ALU_SUB: y = a - b;
			mipsPkg::ALU_OR:  y = a | b;
			mipsPkg::ALU_LUI: y = b << 16;
			mipsPkg::ALU_CLO: y = {26'd0, cloCnt};
			default:          y = '0;
		endcase
	end

endmodule

/* rtl/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore (
	input  logic        clk,
	input  logic        rst,
	output logic [31:0] imAddr,
	input  logic [31:0] imData,
	output logic [31:0] dmAddr,
	output logic        dmWe,
	output logic [31:0] dmWData,
	input  logic [31:0] dmRData,
	output logic        retWe,
	output logic [4:0]  retReg,
	output logic [31:0] retData
);

	logic [31:0] pcF;
	// Decode
	mipsPkg::instrWord_t instrD;
	logic [31:0] pcD, rfA, rfB, rsD, rtD, immD, npcTarget;
	logic [4:0]  dstD;
	logic        redirect, stall;
	logic [1:0]  fwdDA, fwdDB, fwdEA, fwdEB;
	// Execute
	logic [31:0] pcE, rsValE, rtValE, immE, opA, rtFwdE, opB, aluY, resE;
	logic [4:0]  rsE, rtE, dstE;
	logic        regWriteE, memWriteE, aluSrcImmE, isLoadE;
	mipsPkg::aluOp_t aluOpE;
	mipsPkg::wbSel_t wbSelE;
	// Memory
	logic [31:0] resM, rtValM;
	logic [4:0]  dstM;
	logic        regWriteM, memWriteM, isLoadM;
	// Writeback
	logic [31:0] resW, memW, wbData;
	logic [4:0]  dstW;
	logic        regWriteW, isLoadW;

	ctrlBus dBus ();

	// Operand select, own value or a younger result
	function automatic logic [31:0] fwdMux(logic [1:0] sel, logic [31:0] own,
	                                        logic [31:0] mVal, logic [31:0] wVal);
		case (sel)
			mipsPkg::FWD_MEM: return mVal;
			mipsPkg::FWD_WB:  return wVal;
			default:          return own;
		endcase
	endfunction

	////////////////////////////////////////
	// Fetch
	////////////////////////////////////////

	assign imAddr = pcF;

	// Redirect lands after the delay slot already in Fetch
	always_ff @(posedge clk) begin
		if (rst) begin
			pcF    <= mipsPkg::RESET_PC;
			instrD <= '0;    // Decodes as no-op
			pcD    <= mipsPkg::RESET_PC;
		end else if (!stall) begin
			pcF    <= redirect ? npcTarget : pcF + 32'd4;
			instrD <= imData;
			pcD    <= pcF;
		end
	end

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////

	ctrl uCtrl (.instr(instrD), .bus(dBus));

	regFile uRegFile (
		.clk, .rst,
		.raddrA(instrD.rFmt.rs), .raddrB(instrD.rFmt.rt),
		.rdataA(rfA), .rdataB(rfB),
		.we(regWriteW), .waddr(dstW), .wdata(wbData)
	);

	hazardUnit uHazard (
		.dCtrl(dBus), .dRs(instrD.rFmt.rs), .dRt(instrD.rFmt.rt),
		.eDst(dstE), .mDst(dstM), .eRegWrite(regWriteE), .mRegWrite(regWriteM),
		.eIsLoad(isLoadE), .mIsLoad(isLoadM), .wRegWrite(regWriteW), .wDst(dstW),
		.eRs(rsE), .eRt(rtE), .stall, .fwdDA, .fwdDB, .fwdEA, .fwdEB
	);

	assign rsD = fwdMux(fwdDA, rfA, resM, wbData);
	assign rtD = fwdMux(fwdDB, rfB, resM, wbData);

	npcUnit uNpc (
		.pcD, .instr(instrD), .npcOp(dBus.npcOp), .rsVal(rsD), .rtVal(rtD),
		.redirect, .target(npcTarget)
	);

	assign immD = dBus.extSigned ? {{16{instrD.iFmt.imm16[15]}}, instrD.iFmt.imm16}
	                             : {16'd0, instrD.iFmt.imm16};

	always_comb begin
		case (dBus.regDst)
			mipsPkg::DST_RD: dstD = instrD.rFmt.rd;
			mipsPkg::DST_RA: dstD = 5'd31;    // jal link
			default:         dstD = instrD.rFmt.rt;
		endcase
	end

	// Decode/Execute, bubble on stall
	always_ff @(posedge clk) begin
		if (rst || stall) begin
			regWriteE <= 1'b0;
			memWriteE <= 1'b0;
			wbSelE    <= mipsPkg::WB_ALU;
		end else begin
			regWriteE <= dBus.regWrite;
			memWriteE <= dBus.memWrite;
			wbSelE    <= dBus.wbSel;
		end
	end

	always_ff @(posedge clk) begin
		pcE        <= pcD;
		rsValE     <= rsD;
		rtValE     <= rtD;
		immE       <= immD;
		rsE        <= instrD.rFmt.rs;
		rtE        <= instrD.rFmt.rt;
		dstE       <= dstD;
		aluOpE     <= dBus.aluOp;
		aluSrcImmE <= dBus.aluSrcImm;
	end

	////////////////////////////////////////
	// Execute
	////////////////////////////////////////

	assign isLoadE = wbSelE == mipsPkg::WB_MEM;
	assign opA     = fwdMux(fwdEA, rsValE, resM, wbData);
	assign rtFwdE  = fwdMux(fwdEB, rtValE, resM, wbData);    // Also store data
	assign opB     = aluSrcImmE ? immE : rtFwdE;

	aluUnit uAlu (.op(aluOpE), .a(opA), .b(opB), .y(aluY));

	assign resE = (wbSelE == mipsPkg::WB_PC8) ? pcE + 32'd8 : aluY;

	// Execute/Memory
	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteM <= 1'b0;
			memWriteM <= 1'b0;
			isLoadM   <= 1'b0;
		end else begin
			regWriteM <= regWriteE;
			memWriteM <= memWriteE;
			isLoadM   <= isLoadE;
		end
	end

	always_ff @(posedge clk) begin
		resM   <= resE;
		rtValM <= rtFwdE;
		dstM   <= dstE;
	end

	////////////////////////////////////////
	// Memory and Writeback
	////////////////////////////////////////

	assign dmAddr  = resM;
	assign dmWe    = memWriteM;
	assign dmWData = rtValM;

	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteW <= 1'b0;
			isLoadW   <= 1'b0;
		end else begin
			regWriteW <= regWriteM;
			isLoadW   <= isLoadM;
		end
	end

	always_ff @(posedge clk) begin
		resW <= resM;
		memW <= dmRData;    // Combinational read, sampled here
		dstW <= dstM;
	end

	assign wbData = isLoadW ? memW : resW;

	// Retire port, r0 writes stay silent
	assign retWe   = regWriteW && (dstW != 5'd0);
	assign retReg  = dstW;
	assign retData = wbData;

endmodule

/* sim/mipsCore_chk.sv */
`timescale 1ns/1ps

module mipsCore_chk (
	input logic        clk,
	input logic        rst,
	input logic [31:0] imAddr,
	input logic        dmWe,
	input logic        retWe,
	input logic [4:0]  retReg
);

	////////////////////////////////////////
	// Port rules
	////////////////////////////////////////

	// r0 writes never reach the retire port
	retireNotZero: assert property (@(posedge clk) retWe |-> (retReg != 5'd0))
		else $error("retire pulse names register 0");

	// Stage registers clear one edge after rst rises
	quietInReset: assert property (@(posedge clk) rst |=> (!dmWe && !retWe))
		else $error("store or retire while reset is held");

	pcAligned: assert property (@(posedge clk) disable iff (rst) imAddr[1:0] == 2'b00)
		else $error("fetch address is not word aligned");

endmodule

bind mipsCore mipsCore_chk uChk (.*);

/* sim/tbMips.sv */
`timescale 1ns/1ps

module tbMips;

	logic        clk;
	logic        rst;
	logic [31:0] imAddr;
	logic [31:0] imData;
	logic [31:0] dmAddr;
	logic        dmWe;
	logic [31:0] dmWData;
	logic [31:0] dmRData;
	logic        retWe;
	logic [4:0]  retReg;
	logic [31:0] retData;

	mipsPkg::instrWord_t imem [256];    // Word 0 sits at RESET_PC
	logic [31:0]         dmem [256];
	mipsPkg::instrWord_t prog [$];      // Program under construction

	// Seen on the DUT ports
	logic [4:0]  gotReg [$];
	logic [31:0] gotVal [$];
	logic [31:0] gotAddr [$];
	logic [31:0] gotSt [$];
	// Predicted by the ISA model
	logic [4:0]  expReg [$];
	logic [31:0] expVal [$];
	logic [31:0] expAddr [$];
	logic [31:0] expSt [$];

	mipsCore u_mipsCore (.*);

	always #2 clk = ~clk;

	////////////////////////////////////////
	// Memory models and port monitor
	////////////////////////////////////////

	function automatic logic [31:0] fillWord(logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;    // Every address bit matters
	endfunction

	function automatic mipsPkg::instrWord_t fetchWord(logic [31:0] addr);
		if (addr[31:10] == mipsPkg::RESET_PC[31:10]) begin
			return imem[addr[9:2]];
		end
		return '0;    // Outside the program window, no-op
	endfunction

	task automatic initDmem();
		for (int i = 0; i < 256; i++) begin
			dmem[i] = fillWord(32'(i) << 2);
		end
	endtask

	// Outputs are settled mid-cycle
	always @(negedge clk) begin
		if (dmWe) begin
			dmem[dmAddr[9:2]] = dmWData;
			gotAddr.push_back(dmAddr);
			gotSt.push_back(dmWData);
		end
		if (retWe) begin
			gotReg.push_back(retReg);
			gotVal.push_back(retData);
		end
		imData  = fetchWord(imAddr);
		dmRData = dmem[dmAddr[9:2]];    // Read after any store this cycle
	end

	////////////////////////////////////////
	// Instruction builders
	////////////////////////////////////////

	function automatic mipsPkg::instrWord_t rIns(logic [5:0] fn, logic [4:0] rd,
	                                             logic [4:0] rs, logic [4:0] rt);
		mipsPkg::instrWord_t w;
		w           = '0;
		w.rFmt.op   = mipsPkg::OP_RTYPE;
		w.rFmt.rs   = rs;
		w.rFmt.rt   = rt;
		w.rFmt.rd   = rd;
		w.rFmt.func = fn;
		return w;
	endfunction

	// Assembly order, op rt, rs, imm
	function automatic mipsPkg::instrWord_t iIns(logic [5:0] op, logic [4:0] rt,
	                                             logic [4:0] rs, logic [15:0] imm);
		mipsPkg::instrWord_t w;
		w            = '0;
		w.iFmt.op    = op;
		w.iFmt.rs    = rs;
		w.iFmt.rt    = rt;
		w.iFmt.imm16 = imm;
		return w;
	endfunction

	function automatic mipsPkg::instrWord_t jIns(logic [5:0] op, logic [31:0] addr);
		mipsPkg::instrWord_t w;
		w               = '0;
		w.jFmt.op       = op;
		w.jFmt.target26 = addr[27:2];    // Region bits come from the slot PC
		return w;
	endfunction

	function automatic logic [31:0] pcOf(int idx);
		return mipsPkg::RESET_PC + 32'(idx * 4);
	endfunction

	function automatic logic [31:0] leadOnes(logic [31:0] v);
		int n;
		n = 0;
		while (n < 32 && v[31 - n]) begin
			n++;
		end
		return 32'(n);
	endfunction

	////////////////////////////////////////
	// ISA reference model
	////////////////////////////////////////

	task automatic runModel();
		logic [31:0]         r [32];
		logic [31:0]         md [256];
		logic [31:0]         pc;
		logic [31:0]         slot;    // Address after pc, always executes
		logic [31:0]         next;
		logic [31:0]         a;
		logic [31:0]         b;
		logic [31:0]         imm;
		logic [31:0]         ea;
		logic [31:0]         res;
		logic [4:0]          dst;
		logic                wr;
		mipsPkg::instrWord_t w;
		expReg.delete();
		expVal.delete();
		expAddr.delete();
		expSt.delete();
		for (int i = 0; i < 32; i++) begin
			r[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			md[i] = fillWord(32'(i) << 2);
		end
		pc   = mipsPkg::RESET_PC;
		slot = pc + 32'd4;
		for (int step = 0; step < 64; step++) begin
			w    = fetchWord(pc);
			a    = r[w.rFmt.rs];
			b    = r[w.rFmt.rt];
			imm  = {{16{w.iFmt.imm16[15]}}, w.iFmt.imm16};
			ea   = a + imm;
			next = slot + 32'd4;
			wr   = 1'b1;
			dst  = w.iFmt.rt;
			res  = '0;
			case (w.iFmt.op)
				mipsPkg::OP_RTYPE: begin
					dst = w.rFmt.rd;
					case (w.rFmt.func)
						mipsPkg::FN_ADD: res = a + b;
						mipsPkg::FN_SUB: res = a - b;
						mipsPkg::FN_CLO: res = leadOnes(a);
						mipsPkg::FN_JR: begin
							wr   = 1'b0;
							next = a;
						end
						default: wr = 1'b0;
					endcase
				end
				mipsPkg::OP_ORI: res = a | {16'd0, w.iFmt.imm16};
				mipsPkg::OP_LUI: res = {w.iFmt.imm16, 16'd0};
				mipsPkg::OP_LW:  res = md[ea[9:2]];
				mipsPkg::OP_SW: begin
					wr           = 1'b0;
					md[ea[9:2]] = b;
					expAddr.push_back(ea);
					expSt.push_back(b);
				end
				mipsPkg::OP_BEQ: begin
					wr = 1'b0;
					if (a == b) begin
						next = slot + (imm << 2);
					end
				end
				mipsPkg::OP_J: begin
					wr   = 1'b0;
					next = {slot[31:28], w.jFmt.target26, 2'b00};
				end
				mipsPkg::OP_JAL: begin
					dst  = 5'd31;
					res  = pc + 32'd8;    // Link skips the delay slot
					next = {slot[31:28], w.jFmt.target26, 2'b00};
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 5'd0) begin
				r[dst] = res;
				expReg.push_back(dst);
				expVal.push_back(res);
			end
			pc   = slot;
			slot = next;
		end
	endtask

	////////////////////////////////////////
	// Run control and compares
	////////////////////////////////////////

	task automatic abortRun(string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic checkRetire(logic [4:0] gotR, logic [31:0] gotD,
	                           logic [4:0] expR, logic [31:0] expD);
		if (gotR !== expR) begin
			abortRun($sformatf("Mismatch retReg: got %h expected %h", gotR, expR));
		end
		if (gotD !== expD) begin
			abortRun($sformatf("Mismatch retData r%0d: got %h expected %h", gotR, gotD, expD));
		end
	endtask

	task automatic checkStore(logic [31:0] gotA, logic [31:0] gotD,
	                          logic [31:0] expA, logic [31:0] expD);
		if (gotA !== expA) begin
			abortRun($sformatf("Mismatch dmAddr: got %h expected %h", gotA, expA));
		end
		if (gotD !== expD) begin
			abortRun($sformatf("Mismatch dmWData: got %h expected %h", gotD, expD));
		end
	endtask

	// Queues cleared once the pipeline is flushed
	task automatic resetCore();
		@(negedge clk);
		rst = 1'b1;
		@(posedge clk);
		gotReg.delete();
		gotVal.delete();
		gotAddr.delete();
		gotSt.delete();
		initDmem();
		repeat (16) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic waitEvents(int nRet, int nSt);
		int cycles;
		cycles = 0;
		while (gotReg.size() < nRet || gotAddr.size() < nSt) begin
			if (cycles == 400) begin
				abortRun("Timeout: the core stopped retiring before the program finished");
			end
			@(posedge clk);
			cycles++;
		end
	endtask

	task automatic runProgram(string name, int resetAfter);
		@(posedge clk);
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
			if (i < prog.size()) begin
				imem[i] = prog[i];
			end
		end
		runModel();
		resetCore();
		if (resetAfter > 0) begin    // Cut the run short, then start over
			waitEvents(resetAfter, 0);
			resetCore();
		end
		waitEvents(expReg.size(), expAddr.size());
		for (int c = 0; c < 40; c++) begin    // Let stray retires show up
			@(posedge clk);
		end
		if (gotReg.size() != expReg.size() || gotAddr.size() != expAddr.size()) begin
			abortRun($sformatf("%s: core gave %0d retires and %0d stores, model %0d and %0d",
			                   name, gotReg.size(), gotAddr.size(), expReg.size(),
			                   expAddr.size()));
		end
		for (int i = 0; i < expReg.size(); i++) begin
			checkRetire(gotReg[i], gotVal[i], expReg[i], expVal[i]);
		end
		for (int i = 0; i < expAddr.size(); i++) begin
			checkStore(gotAddr[i], gotSt[i], expAddr[i], expSt[i]);
		end
		$display("%s: %0d retires, %0d stores compared", name, expReg.size(), expAddr.size());
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	// Random constants, chained through E and M forwarding
	task automatic buildArith();
		logic [31:0] x;
		logic [31:0] y;
		x = $urandom();
		y = $urandom();
		prog.delete();
		prog.push_back(iIns(mipsPkg::OP_LUI, 5'd1, 5'd0, x[31:16]));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd1, 5'd1, x[15:0]));
		prog.push_back(iIns(mipsPkg::OP_LUI, 5'd2, 5'd0, y[31:16]));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd2, 5'd2, y[15:0]));
		prog.push_back(rIns(mipsPkg::FN_ADD, 5'd3, 5'd1, 5'd2));
		prog.push_back(rIns(mipsPkg::FN_SUB, 5'd4, 5'd3, 5'd1));
		prog.push_back(rIns(mipsPkg::FN_CLO, 5'd5, 5'd4, 5'd0));
		prog.push_back(rIns(mipsPkg::FN_SUB, 5'd6, 5'd0, 5'd1));    // Negative, leading ones
		prog.push_back(rIns(mipsPkg::FN_CLO, 5'd7, 5'd6, 5'd0));
		prog.push_back(iIns(mipsPkg::OP_LUI, 5'd8, 5'd0, 16'hffff));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd8, 5'd8, 16'hffff));
		prog.push_back(rIns(mipsPkg::FN_CLO, 5'd9, 5'd8, 5'd0));    // All ones gives 32
		prog.push_back(rIns(mipsPkg::FN_ADD, 5'd10, 5'd8, 5'd8));   // Wraps
		prog.push_back(rIns(mipsPkg::FN_ADD, 5'd11, 5'd10, 5'd3));
		prog.push_back(rIns(mipsPkg::FN_CLO, 5'd12, 5'd0, 5'd0));
	endtask

	task automatic testArith();
		buildArith();
		runProgram("arithmetic", 0);
	endtask

	task automatic testMemory();
		logic [31:0] x;
		logic [31:0] y;
		x = $urandom();
		y = $urandom();
		prog.delete();
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd1, 5'd0, 16'h0080));    // Base
		prog.push_back(iIns(mipsPkg::OP_LUI, 5'd2, 5'd0, x[31:16]));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd2, 5'd2, x[15:0]));
		prog.push_back(iIns(mipsPkg::OP_SW, 5'd2, 5'd1, 16'h0000));
		prog.push_back(iIns(mipsPkg::OP_LUI, 5'd3, 5'd0, y[31:16]));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd3, 5'd3, y[15:0]));
		prog.push_back(iIns(mipsPkg::OP_SW, 5'd3, 5'd1, 16'hfffc));     // Negative offset
		prog.push_back(iIns(mipsPkg::OP_LW, 5'd4, 5'd1, 16'h0000));
		prog.push_back(rIns(mipsPkg::FN_ADD, 5'd5, 5'd4, 5'd4));        // Load-use
		prog.push_back(iIns(mipsPkg::OP_LW, 5'd6, 5'd1, 16'hfffc));
		prog.push_back(rIns(mipsPkg::FN_ADD, 5'd7, 5'd6, 5'd2));
		prog.push_back(iIns(mipsPkg::OP_SW, 5'd7, 5'd1, 16'h0004));     // Data from E
		prog.push_back(iIns(mipsPkg::OP_LW, 5'd8, 5'd1, 16'h0008));     // Prefilled word
		prog.push_back(rIns(mipsPkg::FN_SUB, 5'd9, 5'd8, 5'd1));
		prog.push_back(iIns(mipsPkg::OP_LW, 5'd10, 5'd1, 16'h0004));
		prog.push_back(iIns(mipsPkg::OP_SW, 5'd10, 5'd1, 16'h000c));    // Load into store data
		runProgram("memory", 0);
	endtask

	task automatic testBranch();
		logic [31:0] k;
		logic [31:0] v;
		k = $urandom();
		v = fillWord(32'h0000_0040);    // Word the lw below returns
		prog.delete();
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd1, 5'd0, k[15:0]));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd2, 5'd0, k[15:0]));
		prog.push_back(iIns(mipsPkg::OP_BEQ, 5'd2, 5'd1, 16'd2));       // Taken, r2 in E
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd3, 5'd0, 16'd1));       // Delay slot
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd4, 5'd0, 16'd2));       // Skipped
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd5, 5'd0, 16'd3));
		prog.push_back(rIns(mipsPkg::FN_ADD, 5'd6, 5'd1, 5'd5));
		prog.push_back(iIns(mipsPkg::OP_BEQ, 5'd1, 5'd6, 16'd5));       // Not taken
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd7, 5'd0, 16'd4));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd8, 5'd0, 16'd5));
		prog.push_back(iIns(mipsPkg::OP_LUI, 5'd13, 5'd0, v[31:16]));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd13, 5'd13, v[15:0]));
		prog.push_back(iIns(mipsPkg::OP_LW, 5'd9, 5'd0, 16'h0040));
		prog.push_back(iIns(mipsPkg::OP_BEQ, 5'd13, 5'd9, 16'd2));      // Waits on the load
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd10, 5'd0, 16'd6));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd11, 5'd0, 16'd7));      // Skipped
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd12, 5'd0, 16'd8));
		runProgram("branch", 0);
	endtask

	task automatic testJump();
		prog.delete();
		prog.push_back(jIns(mipsPkg::OP_JAL, pcOf(6)));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd1, 5'd0, 16'h0011));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd2, 5'd0, 16'h0022));    // Return point
		prog.push_back(jIns(mipsPkg::OP_J, pcOf(8)));
		prog.push_back(rIns(mipsPkg::FN_ADD, 5'd3, 5'd1, 5'd2));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd4, 5'd0, 16'h0044));    // Skipped
		prog.push_back(rIns(mipsPkg::FN_JR, 5'd0, 5'd31, 5'd0));        // Link from M
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd6, 5'd0, 16'h0066));
		prog.push_back(rIns(mipsPkg::FN_ADD, 5'd7, 5'd31, 5'd0));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd9, 5'd0, 16'(pcOf(13))));
		prog.push_back(rIns(mipsPkg::FN_JR, 5'd0, 5'd9, 5'd0));         // r9 still in E
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd10, 5'd0, 16'h00aa));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd11, 5'd0, 16'h00bb));   // Skipped
		prog.push_back(jIns(mipsPkg::OP_JAL, pcOf(16)));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd12, 5'd0, 16'h00cc));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd13, 5'd0, 16'h00dd));   // Skipped
		prog.push_back(rIns(mipsPkg::FN_ADD, 5'd14, 5'd31, 5'd0));
		runProgram("jump", 0);
	endtask

	task automatic testRegZero();
		prog.delete();
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd0, 5'd0, 16'h1234));
		prog.push_back(rIns(mipsPkg::FN_ADD, 5'd1, 5'd0, 5'd0));        // No forward of r0
		prog.push_back(iIns(mipsPkg::OP_LUI, 5'd0, 5'd0, 16'hffff));
		prog.push_back(iIns(mipsPkg::OP_ORI, 5'd2, 5'd0, 16'd5));
		prog.push_back(rIns(mipsPkg::FN_ADD, 5'd0, 5'd2, 5'd2));
		prog.push_back(rIns(mipsPkg::FN_SUB, 5'd3, 5'd0, 5'd2));
		prog.push_back(rIns(mipsPkg::FN_CLO, 5'd4, 5'd0, 5'd0));
		prog.push_back(iIns(mipsPkg::OP_SW, 5'd0, 5'd0, 16'h0020));
		runProgram("register zero", 0);
	endtask

	task automatic testReset();
		buildArith();
		runProgram("mid-run reset", 3);
	endtask

	initial begin
		clk     = 1'b0;
		rst     = 1'b1;
		imData  = '0;
		dmRData = '0;
		void'($urandom(32'h5efa_6ea1));
		initDmem();
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
		end
		testArith();
		testMemory();
		testBranch();
		testJump();
		testRegZero();
		testReset();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* mipsCore.f */
rtl/mipsPkg.sv
rtl/pipeBus.sv
rtl/ctrl.sv
rtl/regFile.sv
rtl/hazardUnit.sv
rtl/npcUnit.sv
rtl/aluUnit.sv
rtl/mipsCore.sv
sim/mipsCore_chk.sv
sim/tbMips.sv

/* Makefile */
SIM        := verilator
TOP        := tbMips
FILELIST   := mipsCore.f
OBJDIR     := obj_dir
SIMFLAGS   := --binary --timing --assert -Wno-fatal
LINTFLAGS  := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
